/* vlog.f */
common/tile_cfg_pkg.sv
common/tile_req_pkg.sv
verilog/spm_bank_remapper.sv
port_alloc/rr_priority_counter.sv
port_alloc/remote_port_allocator.sv
verilog/core_tile_id_remapper.sv
testbench/tb_clk_gen.sv
testbench/tb_core_tile_id_remapper.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, then search the log for the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing -Wno-fatal -f vlog.f \
  --top-module tb_core_tile_id_remapper -o sim_tb \
  && ./obj_dir/sim_tb > "$LOG" 2>&1 \
  || { echo "build or simulation run failed"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"

grep -q "TESTS PASSED" "$LOG" && exit 0 || exit 1

/* testbench/tb_core_tile_id_remapper.sv */
// testbench for the tile request-steering front end
// two DUT builds driven from one table, each checked against its own reference model

`timescale 1ns/1ps

module tb_core_tile_id_remapper
  import tile_cfg_pkg::*;
  import tile_req_pkg::*;
();

  localparam int unsigned NumCores      = 4;
  localparam int unsigned NumPorts      = 5;
  localparam int unsigned NumRd         = 2;
  localparam int unsigned NumWr         = 2;
  localparam int unsigned NumBanks      = 16;
  localparam int unsigned NumTiles      = 4;
  localparam int unsigned MemWidth      = 8;
  localparam int unsigned ByteOff       = 2;
  localparam int unsigned BankBits      = 4;
  localparam int unsigned GroupLsb      = ByteOff + 4 + 2;
  localparam int unsigned NumDirected   = 13;
  localparam int unsigned NumRandom     = 16;
  localparam int unsigned NumRows       = NumDirected + NumRandom;
  localparam int unsigned TimeoutCycles = NumRows + 20;

  typedef addr_t     [NumPorts-1:0] slave_vec_t;
  typedef addr_t     [NumCores-1:0] core_vec_t;
  typedef port_idx_t [NumCores-1:0] port_vec_t;

  logic                 clk;
  logic                 rst_n;
  group_id_t            group_id;
  addr_t                dma_addr;
  slave_vec_t           slave_addr;
  core_vec_t            core_addr;
  core_vec_t            pre_addr;
  logic  [NumCores-1:0] core_valid;
  logic  [NumCores-1:0] core_ready;
  req_op_e [NumCores-1:0] core_op;

  // index 0 is the remap/static build, index 1 the plain/dynamic build
  addr_t      dma_out   [2];
  slave_vec_t slave_out [2];
  core_vec_t  core_out  [2];
  port_vec_t  port_out  [2];

  // stimulus columns
  string                  row_name  [NumRows];
  group_id_t              row_group [NumRows];
  addr_t                  row_dma   [NumRows];
  slave_vec_t             row_slave [NumRows];
  core_vec_t              row_core  [NumRows];
  core_vec_t              row_pre   [NumRows];
  logic    [NumCores-1:0] row_valid [NumRows];
  logic    [NumCores-1:0] row_ready [NumRows];
  req_op_e [NumCores-1:0] row_op    [NumRows];

  // expected columns per build
  addr_t      exp_dma   [2][NumRows];
  slave_vec_t exp_slave [2][NumRows];
  core_vec_t  exp_core  [2][NumRows];
  port_vec_t  exp_port  [2][NumRows];

  int num_rows    = 0;
  int cycle_cnt   = 0;
  int addr_errors = 0;
  int port_errors = 0;

  tb_clk_gen #(
    .ClkPeriodNs (40),
    .ResetCycles (2)
  ) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  for (genvar m = 0; m < 2; m++) begin : gen_mode
    if (m == 0) begin : gen_remap_static
      core_tile_id_remapper #(
        .NumCoresPerTile (NumCores), .NumRemoteReqPortsPerTile (NumPorts),
        .NumRdRemoteReqPortsPerTile (NumRd), .NumWrRemoteReqPortsPerTile (NumWr),
        .NumBanksPerTile (NumBanks), .NumTilesPerGroup (NumTiles),
        .TCDMAddrMemWidth (MemWidth), .ByteOffset (ByteOff),
        .SpmBankIdRemap (1'b1), .DynamicPortAlloc (1'b0)
      ) UUT (
        .clk_i (clk), .rst_n_i (rst_n), .group_id_i (group_id),
        .dma_tgt_addr_i (dma_addr), .slave_tgt_addr_i (slave_addr),
        .core_tgt_addr_i (core_addr), .core_prescramble_addr_i (pre_addr),
        .core_valid_i (core_valid), .core_ready_i (core_ready), .core_op_i (core_op),
        .dma_tgt_addr_o (dma_out[0]), .slave_tgt_addr_o (slave_out[0]),
        .core_tgt_addr_o (core_out[0]), .core_port_sel_o (port_out[0])
      );
    end else begin : gen_plain_dynamic
      core_tile_id_remapper #(
        .NumCoresPerTile (NumCores), .NumRemoteReqPortsPerTile (NumPorts),
        .NumRdRemoteReqPortsPerTile (NumRd), .NumWrRemoteReqPortsPerTile (NumWr),
        .NumBanksPerTile (NumBanks), .NumTilesPerGroup (NumTiles),
        .TCDMAddrMemWidth (MemWidth), .ByteOffset (ByteOff),
        .SpmBankIdRemap (1'b0), .DynamicPortAlloc (1'b1)
      ) UUT (
        .clk_i (clk), .rst_n_i (rst_n), .group_id_i (group_id),
        .dma_tgt_addr_i (dma_addr), .slave_tgt_addr_i (slave_addr),
        .core_tgt_addr_i (core_addr), .core_prescramble_addr_i (pre_addr),
        .core_valid_i (core_valid), .core_ready_i (core_ready), .core_op_i (core_op),
        .dma_tgt_addr_o (dma_out[1]), .slave_tgt_addr_o (slave_out[1]),
        .core_tgt_addr_o (core_out[1]), .core_port_sel_o (port_out[1])
      );
    end
  end

  // bank field replaced by (bank + row bits above it) mod 16
  function automatic addr_t ref_bank_remap(input addr_t addr, input bit remap_on);
    int unsigned bank;
    int unsigned row_bits;
    addr_t       res;
    res = addr;
    if (remap_on) begin
      bank     = addr[BankBits-1:0];
      row_bits = addr[2*BankBits-1:BankBits];
      res[BankBits-1:0] = 4'((bank + row_bits) % NumBanks);
    end
    return res;
  endfunction

  function automatic bit ref_is_local(input int r, input int c);
    return row_pre[r][c][GroupLsb +: GroupIdWidth] == row_group[r];
  endfunction

  function automatic bit ref_remote_hsk(input int r);
    bit hsk;
    hsk = 1'b0;
    for (int c = 0; c < NumCores; c++) begin
      if (row_valid[r][c] && row_ready[r][c] && !ref_is_local(r, c)) hsk = 1'b1;
    end
    return hsk;
  endfunction

  function automatic port_vec_t ref_ports(input int r, input bit dynamic, input int ptr);
    port_vec_t ports;
    int        rank;
    int        c;
    for (int k = 0; k < NumCores; k++) begin
      if (row_op[r][k] == OP_READ) ports[k] = port_idx_t'(1 + k % NumRd);
      else ports[k] = port_idx_t'(1 + NumRd + k % NumWr);
    end
    if (dynamic) begin
      rank = 0;
      for (int k = 0; k < NumCores; k++) begin
        c = (ptr + k) % NumCores;
        if (row_valid[r][c] && !ref_is_local(r, c) && rank < NumPorts - 1) begin
          ports[c] = port_idx_t'(1 + rank);
          rank++;
        end
      end
    end
    for (int k = 0; k < NumCores; k++) begin
      if (ref_is_local(r, k)) ports[k] = '0;
    end
    return ports;
  endfunction

  // varied bank and row bits that differ per row and slot
  function automatic addr_t pattern_addr(input int row, input int slot);
    logic [7:0] hi;
    logic [7:0] lo;
    hi = 8'(row * 37 + slot * 11 + 5);
    lo = 8'(row * 13 + slot * 29 + 3);
    return {8'(row), 8'(slot), hi, lo};
  endfunction

  // tgt_groups, valid, ready and ops are packed with core 0 in the low bits
  task automatic add_directed(input string name, input group_id_t grp,
                              input logic [7:0] tgt_groups, input logic [3:0] valid,
                              input logic [3:0] ready, input logic [7:0] ops);
    int r;
    r = num_rows;
    row_name[r]  = name;
    row_group[r] = grp;
    row_dma[r]   = pattern_addr(r, 0);
    for (int p = 0; p < NumPorts; p++) row_slave[r][p] = pattern_addr(r, 1 + p);
    for (int c = 0; c < NumCores; c++) begin
      row_core[r][c] = pattern_addr(r, 6 + c);
      row_pre[r][c]  = pattern_addr(r, 10 + c);
      row_pre[r][c][GroupLsb +: GroupIdWidth] = tgt_groups[2*c +: 2];
      row_op[r][c]   = req_op_e'(ops[2*c +: 2]);
    end
    row_valid[r] = valid;
    row_ready[r] = ready;
    num_rows++;
  endtask

  task automatic add_random(input int idx);
    int r;
    r = num_rows;
    row_name[r]  = $sformatf("random_%0d", idx);
    row_group[r] = group_id_t'($urandom);
    row_dma[r]   = addr_t'($urandom);
    for (int p = 0; p < NumPorts; p++) row_slave[r][p] = addr_t'($urandom);
    for (int c = 0; c < NumCores; c++) begin
      row_core[r][c] = addr_t'($urandom);
      row_pre[r][c]  = addr_t'($urandom);
      // about half of the requests stay in the own group
      if ($urandom % 2 == 0) row_pre[r][c][GroupLsb +: GroupIdWidth] = row_group[r];
      row_op[r][c]    = req_op_e'(2'($urandom % 3));
      row_valid[r][c] = 1'($urandom);
      row_ready[r][c] = 1'($urandom);
    end
    num_rows++;
  endtask

  task automatic build_table();
    add_directed("remap_local_all",  2'd1, 8'b01_01_01_01, 4'hf, 4'hf, 8'b00_00_00_00);
    add_directed("local_any_op",     2'd2, 8'b10_10_10_10, 4'b0101, 4'b0011, 8'b10_01_00_01);
    add_directed("static_reads_bp",  2'd1, 8'b00_10_11_00, 4'hf, 4'h0, 8'b00_00_00_00);
    add_directed("static_writes_bp", 2'd1, 8'b00_10_11_00, 4'hf, 4'h0, 8'b10_01_10_01);
    add_directed("hsk_ptr0",         2'd0, 8'b11_10_01_11, 4'hf, 4'hf, 8'b00_00_00_00);
    add_directed("hsk_ptr1",         2'd0, 8'b11_10_01_11, 4'hf, 4'hf, 8'b01_01_01_01);
    add_directed("hsk_ptr2",         2'd0, 8'b11_10_01_11, 4'hf, 4'hf, 8'b10_10_10_10);
    add_directed("hsk_ptr3",         2'd0, 8'b11_10_01_11, 4'hf, 4'hf, 8'b00_01_10_00);
    add_directed("wrap_bp",          2'd0, 8'b11_10_01_11, 4'hf, 4'h0, 8'b00_00_00_00);
    add_directed("partial_active",   2'd0, 8'b11_10_01_00, 4'b1011, 4'b0010, 8'b01_00_01_00);
    add_directed("local_only_hsk",   2'd3, 8'b11_11_11_11, 4'hf, 4'hf, 8'b01_00_10_00);
    add_directed("one_ready_hsk",    2'd3, 8'b00_01_10_00, 4'hf, 4'b0100, 8'b00_01_00_10);
    add_directed("single_remote",    2'd2, 8'b10_00_10_10, 4'b0110, 4'b0110, 8'b00_10_00_00);
    for (int i = 0; i < NumRandom; i++) add_random(i);
  endtask

  // the model pointer follows the counter rule row by row from reset
  task automatic build_expected();
    int ptr;
    ptr = 0;
    for (int r = 0; r < NumRows; r++) begin
      for (int m = 0; m < 2; m++) begin
        exp_dma[m][r] = ref_bank_remap(row_dma[r], m == 0);
        for (int p = 0; p < NumPorts; p++) begin
          exp_slave[m][r][p] = ref_bank_remap(row_slave[r][p], m == 0);
        end
        for (int c = 0; c < NumCores; c++) begin
          exp_core[m][r][c] = ref_bank_remap(row_core[r][c], m == 0);
        end
        exp_port[m][r] = ref_ports(r, m == 1, ptr);
      end
      if (ref_remote_hsk(r)) ptr = (ptr == NumCores - 1) ? 0 : ptr + 1;
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp_val, input addr_t act_val);
    if (act_val !== exp_val) begin
      addr_errors++;
      $display("** Error %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic check_port(input string name, input port_idx_t exp_val,
                            input port_idx_t act_val);
    if (act_val !== exp_val) begin
      port_errors++;
      $display("** Error %s: expected %0d, actual %0d", name, exp_val, act_val);
    end
  endtask

  task automatic check_row(input int r);
    string tag;
    for (int m = 0; m < 2; m++) begin
      tag = $sformatf("%s/%s", row_name[r], (m == 0) ? "remap_static" : "plain_dynamic");
      check_addr({tag, " dma"}, exp_dma[m][r], dma_out[m]);
      for (int p = 0; p < NumPorts; p++) begin
        check_addr($sformatf("%s slave%0d", tag, p), exp_slave[m][r][p], slave_out[m][p]);
      end
      for (int c = 0; c < NumCores; c++) begin
        check_addr($sformatf("%s core%0d addr", tag, c), exp_core[m][r][c], core_out[m][c]);
        check_port($sformatf("%s core%0d port", tag, c), exp_port[m][r][c], port_out[m][c]);
      end
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > TimeoutCycles) begin
      $display("timeout: the table did not finish within %0d cycles", TimeoutCycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h36e4));
    group_id   = '0;
    dma_addr   = '0;
    slave_addr = '0;
    core_addr  = '0;
    pre_addr   = '0;
    core_valid = '0;
    core_ready = '0;
    for (int c = 0; c < NumCores; c++) core_op[c] = OP_READ;

    build_table();
    build_expected();

    wait (rst_n === 1'b1);
    for (int r = 0; r < NumRows; r++) begin
      @(posedge clk);
      group_id   <= row_group[r];
      dma_addr   <= row_dma[r];
      slave_addr <= row_slave[r];
      core_addr  <= row_core[r];
      pre_addr   <= row_pre[r];
      core_valid <= row_valid[r];
      core_ready <= row_ready[r];
      core_op    <= row_op[r];
      // outputs are combinational, settled well before the falling edge
      @(negedge clk);
      check_row(r);
    end

    $display("errors: %0d address, %0d port, %0d total",
             addr_errors, port_errors, addr_errors + port_errors);
    if (addr_errors + port_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_core_tile_id_remapper

/* testbench/tb_clk_gen.sv */
// clock and power-on reset for the testbench
// reset is held low for a fixed number of clock cycles

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned ClkPeriodNs = 40,
  parameter int unsigned ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriodNs / 2) clk_o = ~clk_o;
  end

  // release on a rising edge so the first driven row sees a clean counter
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule : tb_clk_gen

/* verilog/core_tile_id_remapper.sv */
// request-steering front end of one tile
// bank remap of DMA, slave and core addresses plus core crossbar port selection

`timescale 1ns/1ps

module core_tile_id_remapper
  import tile_cfg_pkg::*;
  import tile_req_pkg::*;
#(
  parameter int unsigned NumCoresPerTile            = 4,
  parameter int unsigned NumRemoteReqPortsPerTile   = 5,
  parameter int unsigned NumRdRemoteReqPortsPerTile = 2,
  parameter int unsigned NumWrRemoteReqPortsPerTile = 2,
  parameter int unsigned NumBanksPerTile            = 16,
  parameter int unsigned NumTilesPerGroup           = 4,
  parameter int unsigned TCDMAddrMemWidth           = 8,
  parameter int unsigned ByteOffset                 = 2,
  parameter bit          SpmBankIdRemap             = 1'b0,
  parameter bit          DynamicPortAlloc           = 1'b0
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  group_id_t                               group_id_i,
  input  addr_t                                   dma_tgt_addr_i,
  input  addr_t     [NumRemoteReqPortsPerTile-1:0] slave_tgt_addr_i,
  input  addr_t     [NumCoresPerTile-1:0]          core_tgt_addr_i,
  input  addr_t     [NumCoresPerTile-1:0]          core_prescramble_addr_i,
  input  logic      [NumCoresPerTile-1:0]          core_valid_i,
  input  logic      [NumCoresPerTile-1:0]          core_ready_i,
  input  req_op_e   [NumCoresPerTile-1:0]          core_op_i,
  output addr_t                                   dma_tgt_addr_o,
  output addr_t     [NumRemoteReqPortsPerTile-1:0] slave_tgt_addr_o,
  output addr_t     [NumCoresPerTile-1:0]          core_tgt_addr_o,
  output port_idx_t [NumCoresPerTile-1:0]          core_port_sel_o
);

  logic      remote_hsk;
  core_idx_t priority_q;

  // DMA target address
  spm_bank_remapper #(
    .NumAddrs         (1),
    .NumBanksPerTile  (NumBanksPerTile),
    .TCDMAddrMemWidth (TCDMAddrMemWidth),
    .SpmBankIdRemap   (SpmBankIdRemap)
  ) u_dma_remapper (
    .addr_i (dma_tgt_addr_i),
    .addr_o (dma_tgt_addr_o)
  );

  // one address per remote slave port
  spm_bank_remapper #(
    .NumAddrs         (NumRemoteReqPortsPerTile),
    .NumBanksPerTile  (NumBanksPerTile),
    .TCDMAddrMemWidth (TCDMAddrMemWidth),
    .SpmBankIdRemap   (SpmBankIdRemap)
  ) u_slave_remapper (
    .addr_i (slave_tgt_addr_i),
    .addr_o (slave_tgt_addr_o)
  );

  // local payload address of each core
  spm_bank_remapper #(
    .NumAddrs         (NumCoresPerTile),
    .NumBanksPerTile  (NumBanksPerTile),
    .TCDMAddrMemWidth (TCDMAddrMemWidth),
    .SpmBankIdRemap   (SpmBankIdRemap)
  ) u_core_remapper (
    .addr_i (core_tgt_addr_i),
    .addr_o (core_tgt_addr_o)
  );

  rr_priority_counter #(
    .NumCoresPerTile (NumCoresPerTile)
  ) u_priority (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .advance_i  (remote_hsk),
    .priority_o (priority_q)
  );

  remote_port_allocator #(
    .NumCoresPerTile            (NumCoresPerTile),
    .NumRemoteReqPortsPerTile   (NumRemoteReqPortsPerTile),
    .NumRdRemoteReqPortsPerTile (NumRdRemoteReqPortsPerTile),
    .NumWrRemoteReqPortsPerTile (NumWrRemoteReqPortsPerTile),
    .NumBanksPerTile            (NumBanksPerTile),
    .NumTilesPerGroup           (NumTilesPerGroup),
    .ByteOffset                 (ByteOffset),
    .DynamicPortAlloc           (DynamicPortAlloc)
  ) u_port_alloc (
    .group_id_i         (group_id_i),
    .prescramble_addr_i (core_prescramble_addr_i),
    .valid_i            (core_valid_i),
    .ready_i            (core_ready_i),
    .op_i               (core_op_i),
    .priority_i         (priority_q),
    .port_sel_o         (core_port_sel_o),
    .remote_hsk_o       (remote_hsk)
  );

endmodule : core_tile_id_remapper

/* port_alloc/remote_port_allocator.sv */
// per-core crossbar output port selection for the tile
// static split by core index, or rotating dynamic allocation of spare ports

`timescale 1ns/1ps

module remote_port_allocator
  import tile_cfg_pkg::*;
  import tile_req_pkg::*;
#(
  parameter int unsigned NumCoresPerTile            = 4,
  parameter int unsigned NumRemoteReqPortsPerTile   = 5,
  parameter int unsigned NumRdRemoteReqPortsPerTile = 2,
  parameter int unsigned NumWrRemoteReqPortsPerTile = 2,
  parameter int unsigned NumBanksPerTile            = 16,
  parameter int unsigned NumTilesPerGroup           = 4,
  parameter int unsigned ByteOffset                 = 2,
  parameter bit          DynamicPortAlloc           = 1'b0
) (
  input  group_id_t                      group_id_i,
  input  addr_t     [NumCoresPerTile-1:0] prescramble_addr_i,
  input  logic      [NumCoresPerTile-1:0] valid_i,
  input  logic      [NumCoresPerTile-1:0] ready_i,
  input  req_op_e   [NumCoresPerTile-1:0] op_i,
  input  core_idx_t                      priority_i,
  output port_idx_t [NumCoresPerTile-1:0] port_sel_o,
  output logic                           remote_hsk_o
);

  // group field sits above the byte offset, bank index and tile index
  localparam int unsigned GroupLsb =
      ByteOffset + $clog2(NumBanksPerTile) + $clog2(NumTilesPerGroup);

  // every port but the local one can be handed out
  localparam int unsigned NumSparePorts = NumRemoteReqPortsPerTile - 1;

  group_id_t [NumCoresPerTile-1:0] tgt_group_id;
  logic      [NumCoresPerTile-1:0] is_local;
  logic      [NumCoresPerTile-1:0] remote_valid;
  logic      [NumCoresPerTile-1:0] remote_hsk;
  port_idx_t [NumCoresPerTile-1:0] static_port;
  port_idx_t [NumCoresPerTile-1:0] dyn_port;

  for (genvar c = 0; c < NumCoresPerTile; c++) begin : gen_core
    assign tgt_group_id[c] = prescramble_addr_i[c][GroupLsb +: GroupIdWidth];
    assign is_local[c]     = (tgt_group_id[c] == group_id_i);
    assign remote_valid[c] = valid_i[c] & ~is_local[c];
    assign remote_hsk[c]   = remote_valid[c] & ready_i[c];

    // reads fill ports 1.., writes and atomics the ports after them
    assign static_port[c] = op_takes_write_path(op_i[c]) ?
        port_idx_t'(1 + NumRdRemoteReqPortsPerTile + (c % NumWrRemoteReqPortsPerTile)) :
        port_idx_t'(1 + (c % NumRdRemoteReqPortsPerTile));
  end

  // scan the active remote cores from the priority pointer, wrapping
  // the first ones found get the spare ports in order, the rest stay static
  always_comb begin
    int unsigned core_sel;
    int unsigned rank;
    dyn_port = static_port;
    rank     = 0;
    for (int unsigned i = 0; i < NumCoresPerTile; i++) begin
      core_sel = (priority_i + i) % NumCoresPerTile;
      if (remote_valid[core_sel] && (rank < NumSparePorts)) begin
        dyn_port[core_sel] = port_idx_t'(1 + rank);
        rank++;
      end
    end
  end

  for (genvar c = 0; c < NumCoresPerTile; c++) begin : gen_sel
    if (DynamicPortAlloc) begin : gen_dynamic
      assign port_sel_o[c] = is_local[c] ? '0 : dyn_port[c];
    end else begin : gen_static
      assign port_sel_o[c] = is_local[c] ? '0 : static_port[c];
    end
  end

  // any accepted request leaving the tile moves the priority on
  assign remote_hsk_o = |remote_hsk;

endmodule : remote_port_allocator

/* port_alloc/rr_priority_counter.sv */
// rotating priority pointer for dynamic remote port allocation
// steps once per cycle with an accepted remote request

`timescale 1ns/1ps

module rr_priority_counter
  import tile_cfg_pkg::*;
#(
  parameter int unsigned NumCoresPerTile = 4
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      advance_i,
  output core_idx_t priority_o
);

  core_idx_t priority_q;
  core_idx_t priority_d;

  // wrap from the last core back to core 0
  assign priority_d = (priority_q == core_idx_t'(NumCoresPerTile - 1)) ? '0 : priority_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      priority_q <= '0;
    end else if (advance_i) begin
      priority_q <= priority_d;
    end
  end

  assign priority_o = priority_q;

endmodule : rr_priority_counter

/* verilog/spm_bank_remapper.sv */
// combinational bank-index remap for a vector of scratchpad word addresses
// bank bits become (bank + row bits above them) mod bank count when enabled

`timescale 1ns/1ps

module spm_bank_remapper
  import tile_cfg_pkg::*;
#(
  parameter int unsigned NumAddrs         = 1,
  parameter int unsigned NumBanksPerTile  = 16,
  parameter int unsigned TCDMAddrMemWidth = 8,
  parameter bit          SpmBankIdRemap   = 1'b0
) (
  input  addr_t [NumAddrs-1:0] addr_i,
  output addr_t [NumAddrs-1:0] addr_o
);

  localparam int unsigned BankIdxWidth = $clog2(NumBanksPerTile);

  // only as many row bits as fit into the bank index take part in the sum
  localparam int unsigned ShiftWidth =
      (TCDMAddrMemWidth < BankIdxWidth) ? TCDMAddrMemWidth : BankIdxWidth;

  typedef logic [BankIdxWidth-1:0] bank_t;

  for (genvar a = 0; a < NumAddrs; a++) begin : gen_addr
    bank_t bank_id;
    bank_t bank_id_remapped;

    assign bank_id = addr_i[a][BankIdxWidth-1:0];

    if (SpmBankIdRemap) begin : gen_remap
      bank_t                 row_offset;
      logic [BankIdxWidth:0] bank_sum;

      // row bits right above the bank field, zero extended
      assign row_offset = bank_t'(addr_i[a][BankIdxWidth +: ShiftWidth]);

      // one extra bit keeps the carry so the modulo sees the full sum
      assign bank_sum = bank_id + row_offset;

      assign bank_id_remapped = bank_t'(bank_sum % NumBanksPerTile);
    end else begin : gen_no_remap
      assign bank_id_remapped = bank_id;
    end

    // row and upper bits pass through untouched
    assign addr_o[a] = {addr_i[a][AddrWidth-1:BankIdxWidth], bank_id_remapped};
  end

endmodule : spm_bank_remapper

/* common/tile_req_pkg.sv */
// request opcode encoding and crossbar output port index
// with a helper that sorts opcodes onto the read or write path

package tile_req_pkg;

  // opcode of a core request
  typedef enum logic [1:0] {
    OP_READ  = 2'b00,
    OP_WRITE = 2'b01,
    OP_AMO   = 2'b10
  } req_op_e;

  // crossbar output port number
  // port 0 is the local port, ports 1 and up leave the tile
  localparam int unsigned PortIdxWidth = 3;

  typedef logic [PortIdxWidth-1:0] port_idx_t;

  // writes and atomics share the write/atomic ports
  function automatic logic op_takes_write_path(req_op_e op);
    logic is_write;
    is_write = 1'b0;
    case (op)
      OP_WRITE: is_write = 1'b1;
      OP_AMO:   is_write = 1'b1;
      default:  is_write = 1'b0;
    endcase
    return is_write;
  endfunction

endpackage : tile_req_pkg

/* common/tile_cfg_pkg.sv */
// address, group and bank layout types of the tile
// shared by the request-steering RTL and its testbench

package tile_cfg_pkg;

  // word address as seen by the tile interconnect
  localparam int unsigned AddrWidth = 32;

  typedef logic [AddrWidth-1:0] addr_t;

  // group number inside the cluster
  // compared against the group field of a prescrambled address
  localparam int unsigned GroupIdWidth = 2;

  typedef logic [GroupIdWidth-1:0] group_id_t;

  // index of a core inside the tile
  // also sizes the rotating priority pointer of the port allocator
  localparam int unsigned CoreIdxWidth = 2;

  typedef logic [CoreIdxWidth-1:0] core_idx_t;

endpackage : tile_cfg_pkg
